// File: logic/rv_pkg.sv
package rv_pkg;

  // ------------------------------------------------------------------
  // Widths and types
  // ------------------------------------------------------------------
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  localparam word_t reset_pc = 32'h0000_0000;

  // ------------------------------------------------------------------
  // Opcodes
  // ------------------------------------------------------------------
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // addi x0, x0, 0
  localparam word_t instr_nop    = 32'h0000_0013;
  localparam word_t instr_ebreak = 32'h0010_0073;

  // ALU funct3 codes, shared by register and immediate forms
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // Branch funct3 codes
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // ------------------------------------------------------------------
  // Control encodings
  // ------------------------------------------------------------------
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
    alu_sltu, alu_sll, alu_srl, alu_sra, alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {a_rs1, a_pc, a_zero} a_src_e;

  typedef enum logic [1:0] {res_alu, res_load, res_pc4} res_src_e;

  typedef struct packed {
    logic       reg_write;
    logic       mem_write;
    logic       mem_read;
    logic       is_branch;
    logic       is_jump;
    logic       jalr;
    logic       b_imm;
    a_src_e     a_src;
    res_src_e   res_src;
    alu_op_e    alu_op;
    logic [2:0] funct3;
  } ctrl_t;

endpackage

// File: logic/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          pc_sel,
  input  rv_pkg::word_t target,
  input  rv_pkg::word_t imem_data,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4,
  output rv_pkg::word_t instr
);
  import rv_pkg::*;

  // Low through reset and the first cycle after it
  logic started;

  assign pc_plus4 = pc + 32'd4;
  assign instr    = started ? imem_data : instr_nop;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      started <= 1'b0;
      pc      <= reset_pc;
    end else begin
      started <= 1'b1;
      // Hold the PC during the start-up bubble
      if (started) begin
        pc <= pc_sel ? target : pc_plus4;
      end
    end
  end

endmodule

// File: logic/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  rv_pkg::word_t     instr,
  output rv_pkg::ctrl_t     ctrl,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t     imm,
  output logic              ebreak
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  // ------------------------------------------------------------------
  // Field extraction
  // ------------------------------------------------------------------
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ------------------------------------------------------------------
  // Control decode
  // ------------------------------------------------------------------
  always_comb begin
    ctrl           = '0;
    ctrl.a_src     = a_rs1;
    ctrl.res_src   = res_alu;
    ctrl.alu_op    = alu_add;
    ctrl.funct3    = funct3;
    imm            = imm_i;
    ebreak         = 1'b0;

    case (opcode)
      op_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_imm     = 1'b1;
        ctrl.a_src     = a_zero;
        ctrl.alu_op    = alu_pass_b;
        imm            = imm_u;
      end
      op_auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_imm     = 1'b1;
        ctrl.a_src     = a_pc;
        imm            = imm_u;
      end
      op_jal: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.res_src   = res_pc4;
        imm            = imm_j;
      end
      op_jalr: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.jalr      = 1'b1;
        ctrl.b_imm     = 1'b1;
        ctrl.res_src   = res_pc4;
      end
      op_branch: begin
        ctrl.is_branch = 1'b1;
        imm            = imm_b;
      end
      op_load: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.b_imm     = 1'b1;
        ctrl.res_src   = res_load;
      end
      op_store: begin
        ctrl.mem_write = 1'b1;
        ctrl.b_imm     = 1'b1;
        imm            = imm_s;
      end
      op_imm, op_reg: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_imm     = (opcode == op_imm);
        case (funct3)
          // Only the register form has SUB
          f3_add:  ctrl.alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
          f3_sll:  ctrl.alu_op = alu_sll;
          f3_slt:  ctrl.alu_op = alu_slt;
          f3_sltu: ctrl.alu_op = alu_sltu;
          f3_xor:  ctrl.alu_op = alu_xor;
          f3_sr:   ctrl.alu_op = funct7[5] ? alu_sra : alu_srl;
          f3_or:   ctrl.alu_op = alu_or;
          f3_and:  ctrl.alu_op = alu_and;
          default: ctrl.alu_op = alu_add;
        endcase
      end
      op_system: begin
        ebreak = (instr == instr_ebreak);
      end
      default: begin
        // Unknown opcode falls through as a NOP
        ctrl.reg_write = 1'b0;
      end
    endcase
  end

endmodule

// File: logic/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              rd_we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data
);
  import rv_pkg::*;

  // x1 to x31, x0 has no storage
  word_t regs [1:31];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// File: logic/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t imm,
  output rv_pkg::word_t alu_result,
  output logic          pc_sel,
  output rv_pkg::word_t target
);
  import rv_pkg::*;

  word_t      alu_a;
  word_t      alu_b;
  logic [4:0] shamt;
  logic       taken;

  // ------------------------------------------------------------------
  // Operand selection
  // ------------------------------------------------------------------
  always_comb begin
    case (ctrl.a_src)
      a_pc:    alu_a = pc;
      a_zero:  alu_a = '0;
      default: alu_a = rs1_data;
    endcase
  end

  assign alu_b = ctrl.b_imm ? imm : rs2_data;
  assign shamt = alu_b[4:0];

  // ------------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------------
  always_comb begin
    case (ctrl.alu_op)
      alu_add:    alu_result = alu_a + alu_b;
      alu_sub:    alu_result = alu_a - alu_b;
      alu_and:    alu_result = alu_a & alu_b;
      alu_or:     alu_result = alu_a | alu_b;
      alu_xor:    alu_result = alu_a ^ alu_b;
      alu_slt:    alu_result = word_t'($signed(alu_a) < $signed(alu_b));
      alu_sltu:   alu_result = word_t'(alu_a < alu_b);
      alu_sll:    alu_result = alu_a << shamt;
      alu_srl:    alu_result = alu_a >> shamt;
      alu_sra:    alu_result = word_t'($signed(alu_a) >>> shamt);
      alu_pass_b: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

  // ------------------------------------------------------------------
  // Branch and jump
  // ------------------------------------------------------------------
  // Compare on the register values, independent of the ALU inputs
  always_comb begin
    case (ctrl.funct3)
      f3_beq:  taken = (rs1_data == rs2_data);
      f3_bne:  taken = (rs1_data != rs2_data);
      f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: taken = (rs1_data < rs2_data);
      f3_bgeu: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  // JALR target is rs1 + imm with bit 0 cleared
  assign target = ctrl.jalr ? {alu_result[31:1], 1'b0} : pc + imm;
  assign pc_sel = (ctrl.is_branch & taken) | ctrl.is_jump;

endmodule

// File: logic/rv_writeback.sv
`timescale 1ns/1ps

module rv_writeback (
  input  rv_pkg::ctrl_t ctrl,
  input  rv_pkg::word_t alu_result,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t pc_plus4,
  input  rv_pkg::word_t dmem_rdata,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output logic          dmem_we,
  output logic          rd_we,
  output rv_pkg::word_t rd_data
);
  import rv_pkg::*;

  // Data memory port, word access only
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = ctrl.mem_write;

  assign rd_we = ctrl.reg_write;

  // Result select
  always_comb begin
    case (ctrl.res_src)
      res_load: rd_data = dmem_rdata;
      res_pc4:  rd_data = pc_plus4;
      default:  rd_data = alu_result;
    endcase
  end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic          clk,
  input  logic          rst_n,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output rv_pkg::word_t dmem_addr,
  input  rv_pkg::word_t dmem_rdata,
  output rv_pkg::word_t dmem_wdata,
  output logic          dmem_we,
  output logic          ebreak
);
  import rv_pkg::*;

  word_t     pc;
  word_t     pc_plus4;
  word_t     instr;
  ctrl_t     ctrl;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_result;
  logic      pc_sel;
  word_t     target;
  logic      rd_we;
  word_t     rd_data;

  assign imem_addr = pc;

  // ------------------------------------------------------------------
  // Input side
  // ------------------------------------------------------------------
  rv_fetch fetch_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_sel    (pc_sel),
    .target    (target),
    .imem_data (imem_data),
    .pc        (pc),
    .pc_plus4  (pc_plus4),
    .instr     (instr)
  );

  rv_decode decode_i (
    .instr  (instr),
    .ctrl   (ctrl),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .imm    (imm),
    .ebreak (ebreak)
  );

  // Register file and execute
  rv_regfile regfile_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_we    (rd_we),
    .rd       (rd),
    .rd_data  (rd_data)
  );

  rv_execute execute_i (
    .ctrl       (ctrl),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .alu_result (alu_result),
    .pc_sel     (pc_sel),
    .target     (target)
  );

  // Memory access and write-back
  rv_writeback writeback_i (
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .pc_plus4   (pc_plus4),
    .dmem_rdata (dmem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .rd_we      (rd_we),
    .rd_data    (rd_data)
  );

endmodule

// File: testbench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int timeout_cycles = 2000;

  logic  clk;
  logic  rst_n;
  word_t imem_addr;
  word_t imem_data;
  word_t dmem_addr;
  word_t dmem_rdata;
  word_t dmem_wdata;
  logic  dmem_we;
  logic  ebreak;

  word_t imem [256];
  word_t dmem [256];

  // Expected store contents, indexed by word address
  bit    exp_valid [256];
  word_t exp_data [256];
  bit    skipped [256];

  int    wp;
  int    slot;
  int    cyc;
  word_t marker;
  word_t jalr_pc;
  word_t jalr_tgt;
  word_t ebreak_pc;

  rv_core dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .ebreak     (ebreak)
  );

  always #4 clk = ~clk;

  // ------------------------------------------------------------------
  // Memory models
  // ------------------------------------------------------------------
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  // Cycles since reset release
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "run stopped at first error");
  endtask

  // ------------------------------------------------------------------
  // Instruction encoders
  // ------------------------------------------------------------------
  function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic word_t u_type(input word_t u, input reg_addr_t rd,
                                   input logic [6:0] op);
    return {u[31:12], rd, op};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // RV32I compare rule per branch funct3
  function automatic bit branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ------------------------------------------------------------------
  // Program builder
  // ------------------------------------------------------------------
  task automatic emit(input word_t instr);
    imem[wp] = instr;
    wp++;
  endtask

  task automatic load_const(input reg_addr_t rd, input word_t v);
    emit(u_type(v + 32'h800, rd, op_lui));
    emit(i_type(v[11:0], rd, 3'd0, rd, op_imm));
  endtask

  task automatic store_expect(input reg_addr_t rs, input word_t value);
    emit(s_type(12'(slot * 4), rs, 5'd0));
    exp_valid[slot] = 1'b1;
    exp_data[slot]  = value;
    slot++;
  endtask

  // Marker value lives in x20
  task automatic marker_store(input bit executed);
    emit(s_type(12'(slot * 4), 5'd20, 5'd0));
    if (executed) begin
      exp_valid[slot] = 1'b1;
      exp_data[slot]  = marker;
    end else begin
      skipped[slot] = 1'b1;
    end
    slot++;
  endtask

  task automatic r_op(input logic [6:0] f7, input logic [2:0] f3, input word_t value);
    emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
    store_expect(5'd3, value);
  endtask

  task automatic i_op(input logic [11:0] imm, input logic [2:0] f3, input word_t value);
    emit(i_type(imm, 5'd1, f3, 5'd3, op_imm));
    store_expect(5'd3, value);
  endtask

  // Taken branch jumps over the marker store
  task automatic branch_case(input logic [2:0] f3, input reg_addr_t rs2,
                             input word_t a, input word_t b);
    emit(b_type(13'd8, rs2, 5'd5, f3));
    marker_store(!branch_taken(f3, a, b));
  endtask

  task automatic build_program();
    word_t       a;
    word_t       b;
    word_t       u;
    word_t       ra;
    word_t       rb;
    logic [11:0] imm;
    logic [4:0]  sh;
    int          p0;
    int          ld_slot;
    logic [2:0]  kinds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    wp     = 0;
    slot   = 1;
    a      = $urandom;
    b      = $urandom;
    marker = $urandom;

    // Store at reset_pc, held off by the start-up bubble
    store_expect(5'd0, 32'h0000_0000);

    load_const(5'd1, a);
    load_const(5'd2, b);
    load_const(5'd20, marker);

    ld_slot = slot;
    r_op(7'h00, 3'd0, a + b);
    r_op(7'h20, 3'd0, a - b);
    r_op(7'h00, 3'd7, a & b);
    r_op(7'h00, 3'd6, a | b);
    r_op(7'h00, 3'd4, a ^ b);
    r_op(7'h00, 3'd2, word_t'($signed(a) < $signed(b)));
    r_op(7'h00, 3'd3, word_t'(a < b));
    r_op(7'h00, 3'd1, a << b[4:0]);
    r_op(7'h00, 3'd5, a >> b[4:0]);
    r_op(7'h20, 3'd5, word_t'($signed(a) >>> b[4:0]));

    imm = 12'($urandom);
    i_op(imm, 3'd0, a + sext12(imm));
    imm = 12'($urandom);
    i_op(imm, 3'd4, a ^ sext12(imm));
    imm = 12'($urandom);
    i_op(imm, 3'd2, word_t'($signed(a) < $signed(sext12(imm))));
    sh = 5'($urandom);
    i_op({7'h00, sh}, 3'd1, a << sh);
    i_op({7'h20, sh}, 3'd5, word_t'($signed(a) >>> sh));

    u = $urandom & 32'hffff_f000;
    emit(u_type(u, 5'd3, op_lui));
    store_expect(5'd3, u);
    u  = $urandom & 32'hffff_f000;
    p0 = wp;
    emit(u_type(u, 5'd3, op_auipc));
    store_expect(5'd3, word_t'(p0 * 4) + u);

    // Read back the ADD result
    emit(i_type(12'(ld_slot * 4), 5'd0, 3'd2, 5'd4, op_load));
    store_expect(5'd4, a + b);

    ra = $urandom;
    rb = $urandom;
    load_const(5'd5, ra);
    load_const(5'd6, rb);
    for (int k = 0; k < 6; k++) begin
      branch_case(kinds[k], 5'd6, ra, rb);
      branch_case(kinds[k], 5'd5, ra, ra);
    end

    p0 = wp;
    emit(j_type(21'd8, 5'd7));
    marker_store(1'b0);
    store_expect(5'd7, word_t'(p0 * 4 + 4));

    // Odd base, target lands after the skipped store
    jalr_tgt = word_t'((wp + 4) * 4);
    load_const(5'd8, jalr_tgt + 32'd1);
    jalr_pc = word_t'(wp * 4);
    emit(i_type(12'd0, 5'd8, 3'd0, 5'd9, op_jalr));
    marker_store(1'b0);
    store_expect(5'd9, jalr_pc + 32'd4);

    ebreak_pc = word_t'(wp * 4);
    emit(instr_ebreak);
  endtask

  // ------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------
  reset_quiet: assert property (@(posedge clk) cyc == 0 |-> !dmem_we && !ebreak)
    else abort_run($sformatf("** Error dmem_we=%h ebreak=%h in start-up cycle",
                             $sampled(dmem_we), $sampled(ebreak)));

  first_fetch: assert property (@(posedge clk) cyc == 1 |-> imem_addr == reset_pc)
    else abort_run($sformatf("** Error imem_addr: got %h, expected %h",
                             $sampled(imem_addr), reset_pc));

  store_value: assert property (@(posedge clk)
      dmem_we && exp_valid[dmem_addr[9:2]] |-> dmem_wdata == exp_data[dmem_addr[9:2]])
    else abort_run($sformatf("** Error dmem_wdata at %h: got %h, expected %h",
                             $sampled(dmem_addr), $sampled(dmem_wdata),
                             exp_data[$sampled(dmem_addr[9:2])]));

  skip_honored: assert property (@(posedge clk) dmem_we |-> !skipped[dmem_addr[9:2]])
    else abort_run($sformatf("A store reached address %h that should have been skipped",
                             $sampled(dmem_addr)));

  jalr_even: assert property (@(posedge clk) imem_addr == jalr_pc |=> imem_addr == jalr_tgt)
    else abort_run($sformatf("** Error imem_addr after JALR: got %h, expected %h",
                             $sampled(imem_addr), jalr_tgt));

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    int waited;

    clk   = 1'b0;
    rst_n = 1'b1;
    void'($urandom(32'hd934_da3d));
    for (int i = 0; i < 256; i++) begin
      imem[i] = instr_nop;
      dmem[i] = 32'h5a00_0000 | word_t'(i << 2);
    end
    build_program();

    // Reset edge after time zero so the flops see it
    #1;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    waited = 0;
    while (!ebreak && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end

    if (!ebreak) begin
      abort_run("Timeout: ebreak never rose within 2000 cycles");
    end else begin
      assert (imem_addr == ebreak_pc)
        else abort_run($sformatf("** Error imem_addr at ebreak: got %h, expected %h",
                                 imem_addr, ebreak_pc));
      // Every expected store must have landed at its own address
      for (int i = 0; i < 256; i++) begin
        if (exp_valid[i]) begin
          assert (dmem[i] == exp_data[i])
            else abort_run($sformatf("** Error dmem[%h]: got %h, expected %h",
                                     i, dmem[i], exp_data[i]));
        end
      end
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// File: rv_core.f
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_writeback.sv
logic/rv_core.sv
testbench/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/rv_fetch.sv
  - logic/rv_decode.sv
  - logic/rv_regfile.sv
  - logic/rv_execute.sv
  - logic/rv_writeback.sv
  - logic/rv_core.sv
  - target: simulation
    files:
      - testbench/rv_core_tb.sv
